//--- source/cart_pkg.sv
package cart_pkg;

   // **********************************************************************
   // Encodings
   // **********************************************************************

   // Console address map
   typedef enum logic {
      MAP_HIROM = 1'b0,
      MAP_LOROM = 1'b1
   } map_mode_e;

   // One sequencer slot per CLK2 within a CPU cycle
   typedef enum logic [3:0] {
      SLOT_0    = 4'd0,
      SLOT_1    = 4'd1,
      SLOT_2    = 4'd2,
      SLOT_3    = 4'd3,
      SLOT_4    = 4'd4,
      SLOT_5    = 4'd5,
      SLOT_6    = 4'd6,
      SLOT_7    = 4'd7,
      SLOT_8    = 4'd8,
      SLOT_9    = 4'd9,
      SLOT_10   = 4'd10,
      SLOT_11   = 4'd11,
      SLOT_IDLE = 4'd12
   } slot_e;

   // Current owner of the SRAM bus
   typedef enum logic {
      PHASE_SNES = 1'b0,
      PHASE_MCU  = 1'b1
   } phase_e;

   typedef logic [23:0] snes_addr_t;
   typedef logic [19:0] sram_addr_t;
   typedef logic [7:0]  data_t;

   // Console request after the CLK2 register stage
   typedef struct packed {
      snes_addr_t addr;
      logic       rd_n;
      logic       wr_n;
      logic       cs_n;
      logic       cycle_start;
   } snes_req_t;

   // Sequencer outputs for the slot in progress
   typedef struct packed {
      slot_e  slot;
      phase_e phase;
      logic   snes_wr_cycle;
      logic   mcu_wr_cycle;
      logic   we_slot_n;
      logic   oe_slot_n;
      logic   latch_snes_wdata;
      logic   latch_snes_rdata;
      logic   latch_mcu_rdata;
   } slot_ctrl_t;

   // SRAM pins except data
   typedef struct packed {
      sram_addr_t addr;
      logic       we_n;
      logic       oe_n;
      logic       bhe_n;
      logic       ble_n;
   } sram_bus_t;

   // **********************************************************************
   // Constants and slot tables
   // **********************************************************************

   localparam snes_addr_t SAVERAM_BASE    = 24'h1E0000;
   localparam int         CPU_CLK_HIST    = 6;
   // Oldest sample on the left
   // Four low samples followed by two high
   localparam logic [CPU_CLK_HIST-1:0] CYCLE_START_PAT = 6'b000011;
   localparam slot_e      SNES_LATCH_SLOT = SLOT_4;
   localparam slot_e      MCU_LATCH_SLOT  = SLOT_11;

   // Bit n is slot n
   // Bits 15..12 cover idle and unused codes
   localparam logic [15:0] MCU_PHASE_TBL = 16'b0000_1111_1100_0000;

   // Row index is {snes write, mcu write}
   // Active low write strobe per slot
   localparam logic [3:0][15:0] WE_SLOT_N_TBL = {
      16'b1111_0000_0000_0000,
      16'b1111_1111_1100_0000,
      16'b1111_0000_0011_1111,
      16'b1111_1111_1111_1111
   };
   // Read strobe in every phase that does not write
   localparam logic [3:0][15:0] OE_SLOT_N_TBL = {
      16'b1111_1111_1111_1111,
      16'b1111_0000_0011_1111,
      16'b1111_1111_1100_0000,
      16'b1111_0000_0000_0000
   };

endpackage

//--- source/bus_sync.sv
`timescale 1ns/1ps

module bus_sync (
   input  logic                 CLK2,
   input  logic                 arst_n,
   input  cart_pkg::snes_addr_t snes_addr,
   input  logic                 snes_rd_n,
   input  logic                 snes_wr_n,
   input  logic                 snes_cs_n,
   input  logic                 snes_cpu_clk,
   output cart_pkg::snes_req_t  req
);

   // Shift history of the CPU clock, newest sample in bit 0
   logic [cart_pkg::CPU_CLK_HIST-1:0] cpu_clk_hist;
   logic                              cycle_match;

   // Two high samples after four low ones
   // Filters glitches on the slow console clock
   assign cycle_match = (cpu_clk_hist == cart_pkg::CYCLE_START_PAT);

   // **********************************************************************
   // Console bus into the CLK2 domain
   // **********************************************************************

   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         req.addr <= '0;
         // Strobes idle high
         req.rd_n <= 1'b1;
         req.wr_n <= 1'b1;
         req.cs_n <= 1'b1;
      end else begin
         req.addr <= snes_addr;
         req.rd_n <= snes_rd_n;
         req.wr_n <= snes_wr_n;
         req.cs_n <= snes_cs_n;
      end
   end

   // History starts all high, so a clock held high
   // out of reset gives no false cycle start
   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         cpu_clk_hist <= '1;
      end else begin
         cpu_clk_hist <= {cpu_clk_hist[cart_pkg::CPU_CLK_HIST-2:0], snes_cpu_clk};
      end
   end

   // One CLK2 pulse per CPU cycle
   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         req.cycle_start <= 1'b0;
      end else begin
         req.cycle_start <= cycle_match;
      end
   end

endmodule

//--- source/slot_sequencer.sv
`timescale 1ns/1ps

module slot_sequencer (
   input  logic                 CLK2,
   input  logic                 arst_n,
   input  cart_pkg::snes_req_t  req,
   input  logic                 mcu_wr_n,
   input  logic                 mcu_rd_n,
   output cart_pkg::slot_ctrl_t ctrl
);

   cart_pkg::slot_e slot_q;
   cart_pkg::slot_e slot_d;
   // Intents frozen for the whole CPU cycle
   logic            snes_wr_q;
   logic            mcu_wr_q;
   logic            mcu_rd_q;
   logic [1:0]      tbl_row;
   logic            at_snes_latch;
   logic            at_mcu_latch;

   // **********************************************************************
   // Slot FSM
   // **********************************************************************

   always_comb begin
      slot_d = slot_q;
      if (req.cycle_start) begin
         // Restart from any slot
         slot_d = cart_pkg::SLOT_0;
      end else if (slot_q < cart_pkg::SLOT_11) begin
         slot_d = cart_pkg::slot_e'(slot_q + 4'd1);
      end else begin
         // Rest here until the next CPU cycle
         slot_d = cart_pkg::SLOT_IDLE;
      end
   end

   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         slot_q <= cart_pkg::SLOT_IDLE;
      end else begin
         slot_q <= slot_d;
      end
   end

   // Capture write and read intents at the start of the cycle
   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         snes_wr_q <= 1'b0;
         mcu_wr_q  <= 1'b0;
         mcu_rd_q  <= 1'b0;
      end else if (req.cycle_start) begin
         snes_wr_q <= ~req.wr_n;
         mcu_wr_q  <= ~mcu_wr_n;
         mcu_rd_q  <= ~mcu_rd_n;
      end
   end

   // **********************************************************************
   // Table lookup for the current slot
   // **********************************************************************

   assign tbl_row       = {snes_wr_q, mcu_wr_q};
   assign at_snes_latch = (slot_q == cart_pkg::SNES_LATCH_SLOT);
   assign at_mcu_latch  = (slot_q == cart_pkg::MCU_LATCH_SLOT);

   always_comb begin
      ctrl.slot          = slot_q;
      ctrl.phase         = cart_pkg::MCU_PHASE_TBL[slot_q] ? cart_pkg::PHASE_MCU
                                                           : cart_pkg::PHASE_SNES;
      ctrl.snes_wr_cycle = snes_wr_q;
      ctrl.mcu_wr_cycle  = mcu_wr_q;
      ctrl.we_slot_n     = cart_pkg::WE_SLOT_N_TBL[tbl_row][slot_q];
      ctrl.oe_slot_n     = cart_pkg::OE_SLOT_N_TBL[tbl_row][slot_q];
      // Console data settles late in the write, latch near the end
      ctrl.latch_snes_wdata = at_snes_latch & snes_wr_q;
      ctrl.latch_snes_rdata = at_snes_latch & ~snes_wr_q;
      // Last MCU slot
      ctrl.latch_mcu_rdata  = at_mcu_latch & mcu_rd_q & ~mcu_wr_q;
   end

endmodule

//--- source/addr_map.sv
`timescale 1ns/1ps

module addr_map (
   input  cart_pkg::snes_req_t  req,
   input  cart_pkg::slot_ctrl_t ctrl,
   input  cart_pkg::map_mode_e  map_mode,
   input  cart_pkg::snes_addr_t rom_mask,
   input  cart_pkg::snes_addr_t saveram_mask,
   input  logic                 mcu_ena_n,
   input  cart_pkg::snes_addr_t mcu_addr,
   input  logic                 mcu_rd_n,
   input  logic                 mcu_wr_n,
   output cart_pkg::sram_bus_t  sram,
   output logic                 is_rom,
   output logic                 is_saveram,
   output logic                 byte_sel
);

   logic [7:0]           bank;
   cart_pkg::snes_addr_t rom_byte;
   cart_pkg::snes_addr_t sav_byte;
   cart_pkg::snes_addr_t snes_byte;
   cart_pkg::snes_addr_t byte_addr;
   logic                 use_mcu;
   logic                 snes_wr_block;

   assign bank = req.addr[23:16];

   // **********************************************************************
   // Region decode per mapping mode
   // **********************************************************************

   always_comb begin
      if (map_mode == cart_pkg::MAP_HIROM) begin
         is_rom     = req.addr[22] | req.addr[15];
         // Banks 20..3F, offsets 6000..7FFF
         is_saveram = (bank[7:5] == 3'b001) & (req.addr[15:13] == 3'b011);
         rom_byte   = {2'b00, req.addr[21:0]} & rom_mask;
         sav_byte   = cart_pkg::SAVERAM_BASE
                      + ({6'd0, bank[4:0], req.addr[12:0]} & saveram_mask);
      end else begin
         // LoROM, upper half of each bank
         is_rom     = req.addr[15];
         // Banks 70..7D, lower half
         is_saveram = (bank >= 8'h70) & (bank <= 8'h7D) & ~req.addr[15];
         rom_byte   = {2'b00, req.addr[22:16], req.addr[14:0]} & rom_mask;
         sav_byte   = cart_pkg::SAVERAM_BASE
                      + ({5'd0, bank[3:0], req.addr[14:0]} & saveram_mask);
      end
   end

   assign snes_byte = is_saveram ? sav_byte : rom_byte;

   // MCU owns the bus in its phase or in direct mode
   assign use_mcu   = (ctrl.phase == cart_pkg::PHASE_MCU) | ~mcu_ena_n;
   // MCU address goes through unmasked
   assign byte_addr = use_mcu ? mcu_addr : snes_byte;
   assign byte_sel  = byte_addr[0];

   // Console writes only land in save RAM
   assign snes_wr_block = (ctrl.phase == cart_pkg::PHASE_SNES) & ~is_saveram;

   // **********************************************************************
   // SRAM strobes
   // **********************************************************************

   always_comb begin
      sram.addr = byte_addr[20:1];
      if (!mcu_ena_n) begin
         sram.we_n = mcu_wr_n;
         sram.oe_n = mcu_rd_n;
      end else begin
         sram.we_n = ctrl.we_slot_n | snes_wr_block;
         sram.oe_n = ctrl.oe_slot_n;
      end
      // Write picks one lane, odd address is the high byte
      if (!sram.we_n) begin
         sram.bhe_n = ~byte_sel;
         sram.ble_n = byte_sel;
      end else begin
         // Reads enable both lanes
         sram.bhe_n = sram.oe_n;
         sram.ble_n = sram.oe_n;
      end
   end

endmodule

//--- source/data_path.sv
`timescale 1ns/1ps

module data_path (
   input  logic                 CLK2,
   input  logic                 arst_n,
   input  cart_pkg::snes_req_t  req,
   input  cart_pkg::slot_ctrl_t ctrl,
   input  logic                 is_rom,
   input  logic                 is_saveram,
   input  logic                 byte_sel,
   input  logic                 mcu_ena_n,
   input  logic                 mcu_rd_n,
   input  cart_pkg::data_t      snes_wdata,
   input  cart_pkg::data_t      mcu_wdata,
   input  logic [15:0]          sram_rdata,
   output logic [15:0]          sram_wdata,
   output cart_pkg::data_t      snes_rdata,
   output cart_pkg::data_t      mcu_rdata,
   output logic                 snes_buf_oe_n,
   output logic                 snes_buf_dir
);

   cart_pkg::data_t snes_wdata_q;
   cart_pkg::data_t lane_byte;
   cart_pkg::data_t wr_byte;
   logic            snes_bus_op;
   logic            snes_region;
   logic            mcu_rd_stb;

   // **********************************************************************
   // Write side
   // **********************************************************************

   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         snes_wdata_q <= '0;
      end else if (ctrl.latch_snes_wdata) begin
         snes_wdata_q <= snes_wdata;
      end
   end

   // Direct MCU mode always drives MCU data
   assign wr_byte = (mcu_ena_n && ctrl.phase == cart_pkg::PHASE_SNES) ? snes_wdata_q
                                                                     : mcu_wdata;
   // Same byte on both lanes, byte enables pick the target
   assign sram_wdata = {wr_byte, wr_byte};

   // **********************************************************************
   // Read side
   // **********************************************************************

   assign lane_byte  = byte_sel ? sram_rdata[15:8] : sram_rdata[7:0];
   // Slot strobe, or every cycle with read low in direct mode
   assign mcu_rd_stb = ctrl.latch_mcu_rdata | (~mcu_ena_n & ~mcu_rd_n);

   always_ff @(posedge CLK2 or negedge arst_n) begin
      if (!arst_n) begin
         snes_rdata <= '0;
         mcu_rdata  <= '0;
      end else begin
         if (ctrl.latch_snes_rdata) begin
            snes_rdata <= lane_byte;
         end
         if (mcu_rd_stb) begin
            mcu_rdata <= lane_byte;
         end
      end
   end

   // Console data buffer, only for regions this cartridge answers
   assign snes_bus_op   = ~req.rd_n | ~req.wr_n;
   assign snes_region   = (is_rom & ~req.cs_n) | is_saveram;
   assign snes_buf_oe_n = ~(snes_bus_op & snes_region);
   // High drives toward the console
   assign snes_buf_dir  = ~req.rd_n;

endmodule

//--- source/cart_top.sv
`timescale 1ns/1ps

module cart_top (
   input  logic                 CLK2,
   input  logic                 arst_n,
   // Console bus
   input  cart_pkg::snes_addr_t snes_addr,
   input  logic                 snes_rd_n,
   input  logic                 snes_wr_n,
   input  logic                 snes_cs_n,
   input  logic                 snes_cpu_clk,
   input  cart_pkg::data_t      snes_wdata,
   output cart_pkg::data_t      snes_rdata,
   output logic                 snes_buf_oe_n,
   output logic                 snes_buf_dir,
   // Mapper configuration levels
   input  cart_pkg::map_mode_e  map_mode,
   input  cart_pkg::snes_addr_t rom_mask,
   input  cart_pkg::snes_addr_t saveram_mask,
   // MCU port
   input  logic                 mcu_ena_n,
   input  cart_pkg::snes_addr_t mcu_addr,
   input  logic                 mcu_rd_n,
   input  logic                 mcu_wr_n,
   input  cart_pkg::data_t      mcu_wdata,
   output cart_pkg::data_t      mcu_rdata,
   // SRAM
   output cart_pkg::sram_bus_t  sram,
   output logic [15:0]          sram_wdata,
   input  logic [15:0]          sram_rdata
);

   cart_pkg::snes_req_t  req;
   cart_pkg::slot_ctrl_t ctrl;
   logic                 is_rom;
   logic                 is_saveram;
   logic                 byte_sel;

   // **********************************************************************
   // Pipeline stages
   // **********************************************************************

   bus_sync u_bus_sync (
      .CLK2         (CLK2),
      .arst_n       (arst_n),
      .snes_addr    (snes_addr),
      .snes_rd_n    (snes_rd_n),
      .snes_wr_n    (snes_wr_n),
      .snes_cs_n    (snes_cs_n),
      .snes_cpu_clk (snes_cpu_clk),
      .req          (req)
   );

   slot_sequencer u_slot_sequencer (
      .CLK2     (CLK2),
      .arst_n   (arst_n),
      .req      (req),
      .mcu_wr_n (mcu_wr_n),
      .mcu_rd_n (mcu_rd_n),
      .ctrl     (ctrl)
   );

   addr_map u_addr_map (
      .req          (req),
      .ctrl         (ctrl),
      .map_mode     (map_mode),
      .rom_mask     (rom_mask),
      .saveram_mask (saveram_mask),
      .mcu_ena_n    (mcu_ena_n),
      .mcu_addr     (mcu_addr),
      .mcu_rd_n     (mcu_rd_n),
      .mcu_wr_n     (mcu_wr_n),
      .sram         (sram),
      .is_rom       (is_rom),
      .is_saveram   (is_saveram),
      .byte_sel     (byte_sel)
   );

   data_path u_data_path (
      .CLK2          (CLK2),
      .arst_n        (arst_n),
      .req           (req),
      .ctrl          (ctrl),
      .is_rom        (is_rom),
      .is_saveram    (is_saveram),
      .byte_sel      (byte_sel),
      .mcu_ena_n     (mcu_ena_n),
      .mcu_rd_n      (mcu_rd_n),
      .snes_wdata    (snes_wdata),
      .mcu_wdata     (mcu_wdata),
      .sram_rdata    (sram_rdata),
      .sram_wdata    (sram_wdata),
      .snes_rdata    (snes_rdata),
      .mcu_rdata     (mcu_rdata),
      .snes_buf_oe_n (snes_buf_oe_n),
      .snes_buf_dir  (snes_buf_dir)
   );

endmodule

//--- test/cart_checker.sv
`timescale 1ns/1ps

module cart_checker (
   input logic                 CLK2,
   input logic                 arst_n,
   input cart_pkg::sram_bus_t  sram,
   input cart_pkg::phase_e     phase,
   input cart_pkg::snes_req_t  req,
   input cart_pkg::map_mode_e  map_mode,
   input cart_pkg::snes_addr_t saveram_mask,
   input logic                 mcu_ena_n,
   input cart_pkg::snes_addr_t mcu_addr
);

   logic [7:0] bank;
   logic       sav_window;
   logic       mcu_owner;
   logic       odd_lane;

   assign bank = req.addr[23:16];

   // Save RAM window of the console address
   always_comb begin
      if (map_mode == cart_pkg::MAP_HIROM) begin
         // Banks 20..3F at 6000..7FFF
         sav_window = (bank >= 8'h20) && (bank <= 8'h3F)
                      && (req.addr[15:0] >= 16'h6000) && (req.addr[15:0] <= 16'h7FFF);
      end else begin
         // Banks 70..7D below 8000
         sav_window = (bank >= 8'h70) && (bank <= 8'h7D) && !req.addr[15];
      end
   end

   // Master that owns the write
   assign mcu_owner = (phase == cart_pkg::PHASE_MCU) || !mcu_ena_n;
   // Save RAM base is even
   assign odd_lane  = mcu_owner ? mcu_addr[0] : (req.addr[0] & saveram_mask[0]);

   // Never drive and read the SRAM at once
   assert property (@(posedge CLK2) disable iff (!arst_n) !(!sram.we_n && !sram.oe_n))
      else $error("SRAM we_n and oe_n both low");

   // Console writes land only in save RAM
   assert property (@(posedge CLK2) disable iff (!arst_n)
      (phase == cart_pkg::PHASE_SNES && mcu_ena_n && !sram.we_n) |-> sav_window)
      else $error("console write outside save RAM");

   // A write touches only the lane of its byte address
   assert property (@(posedge CLK2) disable iff (!arst_n)
      !sram.we_n |-> (sram.bhe_n == !odd_lane) && (sram.ble_n == odd_lane))
      else $error("wrong byte lanes enabled during a write");

endmodule

bind cart_top cart_checker u_cart_checker (
   .CLK2         (CLK2),
   .arst_n       (arst_n),
   .sram         (sram),
   .phase        (ctrl.phase),
   .req          (req),
   .map_mode     (map_mode),
   .saveram_mask (saveram_mask),
   .mcu_ena_n    (mcu_ena_n),
   .mcu_addr     (mcu_addr)
);

//--- test/cart_tb.sv
`timescale 1ns/1ps

module cart_tb;

   typedef enum logic [1:0] {OP_NONE, OP_RD, OP_WR} op_e;

   typedef struct packed {
      cart_pkg::map_mode_e  mode;
      op_e                  snes_op;
      cart_pkg::snes_addr_t snes_addr;
      cart_pkg::data_t      snes_data;
      op_e                  mcu_op;
      cart_pkg::snes_addr_t mcu_addr;
      cart_pkg::data_t      mcu_data;
      cart_pkg::data_t      exp_snes;
      cart_pkg::data_t      exp_mcu;
      cart_pkg::sram_addr_t exp_addr;
   } entry_t;

   localparam int NUM_ENTRIES = 10;
   // Table length plus margin, one CPU period each, doubled
   localparam realtime WATCHDOG_NS = (NUM_ENTRIES + 4) * 16 * 40.0 * 2;

   logic                 CLK2;
   logic                 arst_n;
   cart_pkg::snes_addr_t snes_addr;
   logic                 snes_rd_n;
   logic                 snes_wr_n;
   logic                 snes_cs_n;
   logic                 snes_cpu_clk;
   cart_pkg::data_t      snes_wdata;
   cart_pkg::data_t      snes_rdata;
   logic                 snes_buf_oe_n;
   logic                 snes_buf_dir;
   cart_pkg::map_mode_e  map_mode;
   cart_pkg::snes_addr_t rom_mask;
   cart_pkg::snes_addr_t saveram_mask;
   logic                 mcu_ena_n;
   cart_pkg::snes_addr_t mcu_addr;
   logic                 mcu_rd_n;
   logic                 mcu_wr_n;
   cart_pkg::data_t      mcu_wdata;
   cart_pkg::data_t      mcu_rdata;
   cart_pkg::sram_bus_t  sram;
   logic [15:0]          sram_wdata;
   logic [15:0]          sram_rdata;

   entry_t               tbl [NUM_ENTRIES];
   cart_pkg::data_t      shadow [cart_pkg::snes_addr_t];
   integer               seed = 22;

   // SRAM model state
   logic [15:0]          mem [0:(1<<20)-1];
   cart_pkg::sram_addr_t wr_addr;
   logic [15:0]          wr_word;
   logic                 wr_hi_n;
   logic                 wr_lo_n;

   cart_top dut (.*);

   always #20 CLK2 = ~CLK2;

   // **********************************************************************
   // SRAM model
   // **********************************************************************

   // Capture mid-cycle so the commit does not race the address switch
   always @(negedge CLK2) begin
      if (sram.we_n === 1'b0) begin
         wr_addr = sram.addr;
         wr_word = sram_wdata;
         wr_hi_n = sram.bhe_n;
         wr_lo_n = sram.ble_n;
      end
   end

   always @(posedge sram.we_n) begin
      if (wr_hi_n === 1'b0) mem[wr_addr][15:8] = wr_word[15:8];
      if (wr_lo_n === 1'b0) mem[wr_addr][7:0] = wr_word[7:0];
   end

   assign sram_rdata = sram.oe_n ? 16'h0000 : mem[sram.addr];

   // **********************************************************************
   // Reference model and checks
   // **********************************************************************

   function automatic cart_pkg::data_t fill_byte(input cart_pkg::snes_addr_t a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
   endfunction

   // Console address to SRAM byte address
   function automatic cart_pkg::snes_addr_t map_addr(input cart_pkg::map_mode_e mode,
                                                     input cart_pkg::snes_addr_t a,
                                                     output logic rom, output logic sav);
      cart_pkg::snes_addr_t off;
      if (mode == cart_pkg::MAP_HIROM) begin
         rom = a[22] | a[15];
         sav = (a[23:16] >= 8'h20) && (a[23:16] <= 8'h3F) && (a[15:0] >= 16'h6000)
               && (a[15:0] <= 16'h7FFF);
         off = sav ? {6'd0, a[20:16], a[12:0]} & saveram_mask : {2'b00, a[21:0]} & rom_mask;
      end else begin
         rom = a[15];
         sav = (a[23:16] >= 8'h70) && (a[23:16] <= 8'h7D) && !a[15];
         off = sav ? {5'd0, a[19:16], a[14:0]} & saveram_mask
                   : {2'b00, a[22:16], a[14:0]} & rom_mask;
      end
      return sav ? cart_pkg::SAVERAM_BASE + off : off;
   endfunction

   function automatic cart_pkg::data_t lookup(input cart_pkg::snes_addr_t b);
      return shadow.exists(b) ? shadow[b] : fill_byte(b);
   endfunction

   task automatic report_error(input string msg);
      $display("[ERROR] %0t ns: %s", $time, msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_data(input string what, input cart_pkg::data_t got,
                             input cart_pkg::data_t exp);
      if (got !== exp) report_error($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic check_addr(input string what, input cart_pkg::sram_addr_t got,
                             input cart_pkg::sram_addr_t exp);
      if (got !== exp) report_error($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) report_error($sformatf("%s got %b expected %b", what, got, exp));
   endtask

   task automatic step(input int n);
      repeat (n) begin
         @(posedge CLK2);
         #5;
      end
   endtask

   task automatic set_entry(input int i, input cart_pkg::map_mode_e mode, input op_e sop,
                            input cart_pkg::snes_addr_t sa, input op_e mop,
                            input cart_pkg::snes_addr_t ma);
      tbl[i] = '0;
      tbl[i].mode      = mode;
      tbl[i].snes_op   = sop;
      tbl[i].snes_addr = sa;
      tbl[i].snes_data = cart_pkg::data_t'($random(seed));
      tbl[i].mcu_op    = mop;
      tbl[i].mcu_addr  = ma;
      tbl[i].mcu_data  = cart_pkg::data_t'($random(seed));
   endtask

   // Console phase runs before the MCU phase in each CPU cycle
   task automatic build_table();
      cart_pkg::snes_addr_t b;
      logic                 rom;
      logic                 sav;
      set_entry(0, cart_pkg::MAP_HIROM, OP_RD, 24'hC01235, OP_NONE, 24'h0);
      set_entry(1, cart_pkg::MAP_HIROM, OP_RD, 24'h009ABC, OP_NONE, 24'h0);
      set_entry(2, cart_pkg::MAP_LOROM, OP_RD, 24'h018001, OP_NONE, 24'h0);
      set_entry(3, cart_pkg::MAP_LOROM, OP_RD, 24'h3FFFFE, OP_NONE, 24'h0);
      set_entry(4, cart_pkg::MAP_HIROM, OP_WR, 24'h206001, OP_NONE, 24'h0);
      set_entry(5, cart_pkg::MAP_HIROM, OP_RD, 24'h206001, OP_NONE, 24'h0);
      set_entry(6, cart_pkg::MAP_LOROM, OP_WR, 24'h008010, OP_NONE, 24'h0);
      set_entry(7, cart_pkg::MAP_LOROM, OP_RD, 24'h008010, OP_NONE, 24'h0);
      set_entry(8, cart_pkg::MAP_HIROM, OP_RD, 24'hC01235, OP_WR, 24'h0F0003);
      set_entry(9, cart_pkg::MAP_LOROM, OP_RD, 24'h7C1234, OP_RD, 24'h0F0003);
      for (int i = 0; i < NUM_ENTRIES; i++) begin
         b = map_addr(tbl[i].mode, tbl[i].snes_addr, rom, sav);
         tbl[i].exp_addr = b[20:1];
         if (tbl[i].snes_op == OP_RD) tbl[i].exp_snes = lookup(b);
         if (tbl[i].snes_op == OP_WR && sav) shadow[b] = tbl[i].snes_data;
         if (tbl[i].mcu_op == OP_WR) shadow[tbl[i].mcu_addr] = tbl[i].mcu_data;
         if (tbl[i].mcu_op == OP_RD) tbl[i].exp_mcu = lookup(tbl[i].mcu_addr);
      end
   endtask

   // **********************************************************************
   // Stimulus
   // **********************************************************************

   // One CPU clock period, high half first, then checks
   task automatic apply_entry(input entry_t e);
      map_mode     = e.mode;
      snes_addr    = e.snes_addr;
      snes_wdata   = e.snes_data;
      snes_rd_n    = (e.snes_op != OP_RD);
      snes_wr_n    = (e.snes_op != OP_WR);
      snes_cs_n    = (e.snes_op == OP_NONE);
      mcu_addr     = e.mcu_addr;
      mcu_wdata    = e.mcu_data;
      mcu_rd_n     = (e.mcu_op != OP_RD);
      mcu_wr_n     = (e.mcu_op != OP_WR);
      snes_cpu_clk = 1'b1;
      step(8);
      snes_cpu_clk = 1'b0;
      step(8);
      check_addr("sram address", sram.addr, e.exp_addr);
      check_bit("snes_buf_oe_n", snes_buf_oe_n, 1'b0);
      check_bit("snes_buf_dir", snes_buf_dir, e.snes_op == OP_RD);
      if (e.snes_op == OP_RD) check_data("snes_rdata", snes_rdata, e.exp_snes);
      if (e.mcu_op == OP_RD) check_data("mcu_rdata", mcu_rdata, e.exp_mcu);
   endtask

   // MCU takes the SRAM directly, CPU clock stopped
   task automatic direct_mcu();
      cart_pkg::data_t d;
      d = cart_pkg::data_t'($random(seed));
      snes_rd_n = 1'b1;
      snes_wr_n = 1'b1;
      mcu_rd_n  = 1'b1;
      mcu_wr_n  = 1'b1;
      mcu_ena_n = 1'b0;
      mcu_addr  = 24'h0A5557;
      mcu_wdata = d;
      step(1);
      mcu_wr_n = 1'b0;
      step(2);
      mcu_wr_n = 1'b1;
      step(1);
      mcu_rd_n = 1'b0;
      step(2);
      mcu_rd_n = 1'b1;
      step(1);
      check_data("direct mcu_rdata", mcu_rdata, d);
   endtask

   initial begin
      #WATCHDOG_NS;
      $display("Watchdog timeout, the run did not finish in time");
      $display("Test failed");
      $fatal(1);
   end

   initial begin
      CLK2 = 1'b0;
      arst_n = 1'b0;
      snes_addr = '0;
      snes_rd_n = 1'b1;
      snes_wr_n = 1'b1;
      snes_cs_n = 1'b1;
      snes_cpu_clk = 1'b0;
      snes_wdata = '0;
      map_mode = cart_pkg::MAP_HIROM;
      rom_mask = 24'h3FFFFF;
      saveram_mask = 24'h001FFF;
      mcu_ena_n = 1'b1;
      mcu_addr = '0;
      mcu_rd_n = 1'b1;
      mcu_wr_n = 1'b1;
      mcu_wdata = '0;
      for (int w = 0; w < (1 << 20); w++) begin
         mem[w] = {fill_byte(cart_pkg::snes_addr_t'(2 * w + 1)),
                   fill_byte(cart_pkg::snes_addr_t'(2 * w))};
      end
      build_table();
      step(10);
      arst_n = 1'b1;
      // Idle bus with the CPU clock low
      step(8);
      check_bit("we_n after reset", sram.we_n, 1'b1);
      check_bit("oe_n after reset", sram.oe_n, 1'b1);
      check_bit("bhe_n after reset", sram.bhe_n, 1'b1);
      check_bit("ble_n after reset", sram.ble_n, 1'b1);
      check_bit("snes_buf_oe_n after reset", snes_buf_oe_n, 1'b1);
      for (int i = 0; i < NUM_ENTRIES; i++) apply_entry(tbl[i]);
      direct_mcu();
      $display("Test completed successfully");
      $finish;
   end

endmodule

//--- tb.f
source/cart_pkg.sv
source/bus_sync.sv
source/slot_sequencer.sv
source/addr_map.sv
source/data_path.sv
source/cart_top.sv
test/cart_checker.sv
test/cart_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cart_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
